//--- design/xbar_pkg.sv
`default_nettype none

package xbar_pkg;

  // ========================================
  // crossbar control
  // ========================================

  // picks one of the two ports on a side
  typedef logic xbar_sel_t;

  // control word, sits in the 16-bit word of a config message
  // out_sel is bit 0 and in_sel is bit 1
  typedef struct packed {
    logic [13:0] reserved;
    xbar_sel_t   in_sel;
    xbar_sel_t   out_sel;
  } xbar_ctrl_t;

  // all zero means input 0 straight to output 0

endpackage

`default_nettype wire

//--- design/msg_pkg.sv
`default_nettype none

package msg_pkg;

  // ========================================
  // field widths
  // ========================================

  localparam int ADDR_BITS = 4;
  localparam int DATA_BITS = 16;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [DATA_BITS-1:0] data_t;

  // ========================================
  // message word
  // ========================================

  // plain payload on inject and loopback ports
  // control word on crossbar config ports
  typedef union packed {
    data_t                data;
    xbar_pkg::xbar_ctrl_t ctrl;
  } word_u;

  // full request or response, address on top
  typedef struct packed {
    addr_t addr;
    word_u word;
  } msg_t;

  // streams, ready runs the other way on its own wire
  typedef struct packed {
    logic val;
    msg_t msg;
  } msg_stream_t;

  // address already stripped inside the fabric
  typedef struct packed {
    logic  val;
    word_u word;
  } data_stream_t;

endpackage

`default_nettype wire

//--- design/msg_router.sv
`timescale 1ns/1ps
`default_nettype none

module msg_router #(
  parameter int NUM_XBARS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  msg_pkg::msg_stream_t  in_i,
  output logic                  in_rdy_o,
  output msg_pkg::data_stream_t port_o     [2*NUM_XBARS+1],
  input  logic                  port_rdy_i [2*NUM_XBARS+1]
);

  localparam int NUM_PORTS = 2 * NUM_XBARS + 1;

  // last mapped address, everything above it is dropped
  localparam msg_pkg::addr_t LOOP_ADDR = msg_pkg::addr_t'(2 * NUM_XBARS);

  logic          full_q;
  msg_pkg::msg_t msg_q;
  logic          accept;
  logic          mapped;
  logic          sel_rdy;
  logic          drain;

  // ========================================
  // address decode
  // ========================================

  assign mapped = (msg_q.addr <= LOOP_ADDR);

  // ready of the port the held message is aimed at
  always_comb begin
    sel_rdy = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (msg_q.addr == msg_pkg::addr_t'(i)) begin
        sel_rdy = port_rdy_i[i];
      end
    end
  end

  // an unmapped message never waits on a port
  assign drain    = full_q && (!mapped || sel_rdy);
  assign in_rdy_o = !full_q || drain;
  assign accept   = in_i.val && in_rdy_o;

  // ========================================
  // holding register
  // ========================================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      msg_q <= in_i.msg;
    end
  end

  // word fans out to every port, only the addressed one is valid
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      port_o[i].val  = full_q && (msg_q.addr == msg_pkg::addr_t'(i));
      port_o[i].word = msg_q.word;
    end
  end

endmodule

`default_nettype wire

//--- design/blocking_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module blocking_xbar (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  msg_pkg::data_stream_t cfg_i,
  input  msg_pkg::data_stream_t recv_i     [2],
  output logic                  recv_rdy_o [2],
  output msg_pkg::data_stream_t send_o     [2],
  input  logic                  send_rdy_i [2]
);

  xbar_pkg::xbar_ctrl_t  ctrl_q;
  msg_pkg::data_stream_t sel_in;
  logic                  sel_rdy;

  // ========================================
  // config register
  // ========================================

  // config port never stalls, new word used from the next cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (cfg_i.val) begin
      ctrl_q <= cfg_i.word.ctrl;
    end
  end

  // ========================================
  // data path
  // ========================================

  // the one connected pair
  assign sel_in  = recv_i[ctrl_q.in_sel];
  assign sel_rdy = send_rdy_i[ctrl_q.out_sel];

  // unselected input sees no ready
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      recv_rdy_o[p] = (ctrl_q.in_sel == xbar_pkg::xbar_sel_t'(p)) && sel_rdy;
    end
  end

  // unselected output never shows val
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      send_o[p].val  = (ctrl_q.out_sel == xbar_pkg::xbar_sel_t'(p)) && sel_in.val;
      send_o[p].word = sel_in.word;
    end
  end

endmodule

`default_nettype wire

//--- design/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int NUM_XBARS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  msg_pkg::data_stream_t recv_i     [2*NUM_XBARS+1],
  output logic                  recv_rdy_o [2*NUM_XBARS+1],
  output msg_pkg::msg_stream_t  out_o,
  input  logic                  out_rdy_i
);

  localparam int NUM_INPUTS = 2 * NUM_XBARS + 1;

  // pointer starts here so input 0 wins first
  localparam msg_pkg::addr_t LAST_IDX = msg_pkg::addr_t'(NUM_INPUTS - 1);

  msg_pkg::addr_t ptr_q;
  logic           out_val_q;
  msg_pkg::msg_t  out_msg_q;
  logic           found;
  msg_pkg::addr_t gnt_idx;
  msg_pkg::word_u gnt_word;
  logic           drain;
  logic           load;

  // ========================================
  // grant search
  // ========================================

  // scan from the input after the last winner, wrapping once
  always_comb begin
    int idx;
    found    = 1'b0;
    gnt_idx  = '0;
    gnt_word = '0;
    for (int k = 1; k <= NUM_INPUTS; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= NUM_INPUTS) begin
        idx = idx - NUM_INPUTS;
      end
      if (!found && recv_i[idx].val) begin
        found    = 1'b1;
        gnt_idx  = msg_pkg::addr_t'(idx);
        gnt_word = recv_i[idx].word;
      end
    end
  end

  // register takes a new word when empty or leaving this cycle
  assign drain = out_val_q && out_rdy_i;
  assign load  = found && (!out_val_q || drain);

  always_comb begin
    for (int i = 0; i < NUM_INPUTS; i++) begin
      recv_rdy_o[i] = load && (gnt_idx == msg_pkg::addr_t'(i));
    end
  end

  // ========================================
  // output register
  // ========================================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_val_q <= 1'b0;
      ptr_q     <= LAST_IDX;
    end else if (load) begin
      out_val_q <= 1'b1;
      ptr_q     <= gnt_idx;
    end else if (drain) begin
      out_val_q <= 1'b0;
    end
  end

  // source index goes out in the address field
  always_ff @(posedge clk) begin
    if (load) begin
      out_msg_q.addr <= gnt_idx;
      out_msg_q.word <= gnt_word;
    end
  end

  assign out_o = '{val: out_val_q, msg: out_msg_q};

endmodule

`default_nettype wire

//--- design/interconnect_top.sv
`timescale 1ns/1ps
`default_nettype none

module interconnect_top #(
  parameter int NUM_XBARS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  msg_pkg::msg_stream_t  in_i,
  output logic                  in_rdy_o,
  output msg_pkg::msg_stream_t  out_o,
  input  logic                  out_rdy_i,
  input  msg_pkg::data_stream_t chain_in_i,
  output logic                  chain_in_rdy_o,
  output msg_pkg::data_stream_t chain_out_o,
  input  logic                  chain_out_rdy_i
);

  localparam int NUM_PORTS = 2 * NUM_XBARS + 1;
  localparam int LOOP_IDX  = 2 * NUM_XBARS;

  // router side: 2i inject, 2i+1 config, last one loopback
  msg_pkg::data_stream_t rt_port   [NUM_PORTS];
  logic                  rt_rdy    [NUM_PORTS];

  // arbiter side: 2i from crossbar i, last one loopback
  msg_pkg::data_stream_t arb_in    [NUM_PORTS];
  logic                  arb_rdy   [NUM_PORTS];

  // chain link i feeds input 1 of crossbar i
  msg_pkg::data_stream_t chain     [NUM_XBARS+1];
  logic                  chain_rdy [NUM_XBARS+1];

  // ========================================
  // router
  // ========================================

  msg_router #(
    .NUM_XBARS(NUM_XBARS)
  ) u_router (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .in_i      (in_i),
    .in_rdy_o  (in_rdy_o),
    .port_o    (rt_port),
    .port_rdy_i(rt_rdy)
  );

  // ========================================
  // crossbar row
  // ========================================

  assign chain[0]             = chain_in_i;
  assign chain_in_rdy_o       = chain_rdy[0];
  assign chain_out_o          = chain[NUM_XBARS];
  assign chain_rdy[NUM_XBARS] = chain_out_rdy_i;

  for (genvar i = 0; i < NUM_XBARS; i++) begin : g_xbar
    msg_pkg::data_stream_t xb_recv     [2];
    logic                  xb_recv_rdy [2];
    msg_pkg::data_stream_t xb_send     [2];
    logic                  xb_send_rdy [2];

    // input 0 from the router, input 1 from the chain
    assign xb_recv[0]      = rt_port[2*i];
    assign rt_rdy[2*i]     = xb_recv_rdy[0];
    assign xb_recv[1]      = chain[i];
    assign chain_rdy[i]    = xb_recv_rdy[1];

    // output 0 to the arbiter, output 1 down the chain
    assign arb_in[2*i]     = xb_send[0];
    assign xb_send_rdy[0]  = arb_rdy[2*i];
    assign chain[i+1]      = xb_send[1];
    assign xb_send_rdy[1]  = chain_rdy[i+1];

    // config always accepted
    assign rt_rdy[2*i+1]   = 1'b1;

    // no arbiter input behind a config address
    assign arb_in[2*i+1]   = '0;

    blocking_xbar u_xbar (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .cfg_i     (rt_port[2*i+1]),
      .recv_i    (xb_recv),
      .recv_rdy_o(xb_recv_rdy),
      .send_o    (xb_send),
      .send_rdy_i(xb_send_rdy)
    );
  end

  // loopback goes straight across
  assign arb_in[LOOP_IDX] = rt_port[LOOP_IDX];
  assign rt_rdy[LOOP_IDX] = arb_rdy[LOOP_IDX];

  // ========================================
  // arbiter
  // ========================================

  rr_arbiter #(
    .NUM_XBARS(NUM_XBARS)
  ) u_arbiter (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .recv_i    (arb_in),
    .recv_rdy_o(arb_rdy),
    .out_o     (out_o),
    .out_rdy_i (out_rdy_i)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS = 100.0
) (
  output logic clk_o
);

  // free running, low for the first half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module tb_interconnect;

  localparam int NUM_XBARS   = 3;
  localparam int NUM_ENTRIES = 20;
  localparam int MAX_CYCLES  = NUM_ENTRIES * 64 + 100;
  localparam int SEED        = 90493;

  // what an entry sends and where its answer shows up
  typedef enum logic [2:0] {
    K_MSG,
    K_CFG,
    K_DROP,
    K_CHAIN_OUT,
    K_CHAIN_IN
  } kind_e;

  typedef struct packed {
    kind_e          kind;
    msg_pkg::msg_t  in_msg;
    msg_pkg::data_t chain_word;
    msg_pkg::msg_t  exp_msg;
    logic           stall;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  msg_pkg::msg_stream_t  in_s;
  logic                  in_rdy;
  msg_pkg::msg_stream_t  out_s;
  logic                  out_rdy;
  msg_pkg::data_stream_t chain_in_s;
  logic                  chain_in_rdy;
  msg_pkg::data_stream_t chain_out_s;
  logic                  chain_out_rdy;

  entry_t tbl [NUM_ENTRIES];
  int     cycles = 0;

  tb_clock_gen #(
    .PERIOD_NS(100.0)
  ) u_clk_gen (
    .clk_o(clk)
  );

  interconnect_top #(
    .NUM_XBARS(NUM_XBARS)
  ) DUT (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .in_i           (in_s),
    .in_rdy_o       (in_rdy),
    .out_o          (out_s),
    .out_rdy_i      (out_rdy),
    .chain_in_i     (chain_in_s),
    .chain_in_rdy_o (chain_in_rdy),
    .chain_out_o    (chain_out_s),
    .chain_out_rdy_i(chain_out_rdy)
  );

  // ========================================
  // error handling and compares
  // ========================================

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_msg(input msg_pkg::msg_t got, input msg_pkg::msg_t exp,
                           input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s gave addr %0d data %h, expected addr %0d data %h",
               $time, what, got.addr, got.word.data, exp.addr, exp.word.data);
      stop_on_error();
    end
  endtask

  task automatic check_word(input msg_pkg::data_t got, input msg_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s gave data %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // hard stop if a handshake never completes
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
      stop_on_error();
    end
  end

  // ========================================
  // table
  // ========================================

  function automatic msg_pkg::msg_t req_msg(input msg_pkg::addr_t addr,
                                            input msg_pkg::data_t data);
    msg_pkg::msg_t m;
    m.addr      = addr;
    m.word.data = data;
    return m;
  endfunction

  function automatic msg_pkg::msg_t cfg_msg(input msg_pkg::addr_t addr,
                                            input logic in_sel, input logic out_sel);
    xbar_pkg::xbar_ctrl_t c;
    msg_pkg::msg_t        m;
    c.reserved  = '0;
    c.in_sel    = in_sel;
    c.out_sel   = out_sel;
    m.addr      = addr;
    m.word.ctrl = c;
    return m;
  endfunction

  function automatic entry_t new_entry(input kind_e kind, input msg_pkg::msg_t in_msg,
                                       input msg_pkg::data_t chain_word,
                                       input msg_pkg::msg_t exp_msg, input logic stall);
    entry_t e;
    e.kind       = kind;
    e.in_msg     = in_msg;
    e.chain_word = chain_word;
    e.exp_msg    = exp_msg;
    e.stall      = stall;
    return e;
  endfunction

  task automatic fill_table();
    msg_pkg::data_t d;
    // crossbar i answers as source 2i by default
    tbl[0]  = new_entry(K_MSG, req_msg(4'd0, 16'h1234), '0, req_msg(4'd0, 16'h1234), 1'b0);
    tbl[1]  = new_entry(K_MSG, req_msg(4'd2, 16'hA5A5), '0, req_msg(4'd2, 16'hA5A5), 1'b0);
    tbl[2]  = new_entry(K_MSG, req_msg(4'd4, 16'h0F0F), '0, req_msg(4'd4, 16'h0F0F), 1'b0);
    // loopback sits at address 6
    tbl[3]  = new_entry(K_MSG, req_msg(4'd6, 16'hBEEF), '0, req_msg(4'd6, 16'hBEEF), 1'b0);
    // unmapped address followed by a normal one
    tbl[4]  = new_entry(K_DROP, req_msg(4'd9, 16'hDEAD), '0, '0, 1'b0);
    tbl[5]  = new_entry(K_MSG, req_msg(4'd4, 16'h5A5A), '0, req_msg(4'd4, 16'h5A5A), 1'b0);
    // burst to crossbar 1 with the sink stalling
    for (int k = 0; k < 6; k++) begin
      d          = msg_pkg::data_t'(16'h0100 + k);
      tbl[6 + k] = new_entry(K_MSG, req_msg(4'd2, d), '0, req_msg(4'd2, d), 1'b1);
    end
    // xbar 0 in0 to out1 and xbar 1 in1 to out0
    tbl[12] = new_entry(K_CFG, cfg_msg(4'd1, 1'b0, 1'b1), '0, '0, 1'b0);
    tbl[13] = new_entry(K_CFG, cfg_msg(4'd3, 1'b1, 1'b0), '0, '0, 1'b0);
    tbl[14] = new_entry(K_MSG, req_msg(4'd0, 16'hC0DE), '0, req_msg(4'd2, 16'hC0DE), 1'b0);
    // xbar 1 in0 to out1 and xbar 2 in1 to out1
    tbl[15] = new_entry(K_CFG, cfg_msg(4'd3, 1'b0, 1'b1), '0, '0, 1'b0);
    tbl[16] = new_entry(K_CFG, cfg_msg(4'd5, 1'b1, 1'b1), '0, '0, 1'b0);
    tbl[17] = new_entry(K_CHAIN_OUT, req_msg(4'd2, 16'hFACE), '0, req_msg(4'd0, 16'hFACE),
                        1'b0);
    // xbar 0 in1 to out0 so the chain input lands on source 0
    tbl[18] = new_entry(K_CFG, cfg_msg(4'd1, 1'b1, 1'b0), '0, '0, 1'b0);
    tbl[19] = new_entry(K_CHAIN_IN, '0, 16'h7777, req_msg(4'd0, 16'h7777), 1'b0);
  endtask

  // ========================================
  // drivers and monitors
  // ========================================

  task automatic send_request(input msg_pkg::msg_t m);
    msg_pkg::msg_stream_t s;
    s.val = 1'b1;
    s.msg = m;
    @(posedge clk);
    in_s <= s;
    @(negedge clk);
    while (!in_rdy) begin
      @(negedge clk);
    end
    // transfer happens on this edge
    @(posedge clk);
    in_s.val <= 1'b0;
  endtask

  task automatic send_chain_word(input msg_pkg::data_t w);
    msg_pkg::data_stream_t s;
    s.val       = 1'b1;
    s.word.data = w;
    @(posedge clk);
    chain_in_s <= s;
    @(negedge clk);
    while (!chain_in_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    chain_in_s.val <= 1'b0;
  endtask

  task automatic wait_response(input msg_pkg::msg_t exp, input logic stall);
    msg_pkg::msg_t held;
    int unsigned   hold;
    @(negedge clk);
    while (!out_s.val) begin
      @(negedge clk);
    end
    if (stall) begin
      // out_o must sit still while the sink is busy
      held = out_s.msg;
      hold = 1 + ($urandom % 8);
      repeat (hold) begin
        @(negedge clk);
        if (!out_s.val) begin
          $display("ERROR at %0t ns: out_o.val fell while out_rdy_i was low", $time);
          stop_on_error();
        end
        check_msg(out_s.msg, held, "stalled out_o");
      end
      @(posedge clk);
      out_rdy <= 1'b1;
      @(negedge clk);
    end
    check_msg(out_s.msg, exp, "out_o");
    @(posedge clk);
    // sink busy again for the next word
    if (stall) begin
      out_rdy <= 1'b0;
    end
  endtask

  task automatic wait_chain_word(input msg_pkg::data_t exp);
    @(negedge clk);
    while (!chain_out_s.val) begin
      @(negedge clk);
    end
    check_word(chain_out_s.word.data, exp, "chain_out_o");
    @(posedge clk);
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      if (out_s.val || chain_out_s.val) begin
        $display("ERROR at %0t ns: output valid where no response was expected", $time);
        stop_on_error();
      end
    end
  endtask

  task automatic run_entry(input entry_t e);
    case (e.kind)
      K_CFG: begin
        send_request(e.in_msg);
      end
      K_DROP: begin
        send_request(e.in_msg);
        expect_quiet(10);
      end
      K_CHAIN_OUT: begin
        send_request(e.in_msg);
        wait_chain_word(e.exp_msg.word.data);
      end
      K_CHAIN_IN: begin
        send_chain_word(e.chain_word);
        wait_response(e.exp_msg, e.stall);
      end
      default: begin
        send_request(e.in_msg);
        wait_response(e.exp_msg, e.stall);
      end
    endcase
  endtask

  // requests go in back to back while responses are drained in order
  task automatic burst_with_stalls(input int first, input int count);
    @(posedge clk);
    out_rdy <= 1'b0;
    fork
      begin
        for (int k = 0; k < count; k++) begin
          send_request(tbl[first + k].in_msg);
        end
      end
      begin
        for (int k = 0; k < count; k++) begin
          wait_response(tbl[first + k].exp_msg, 1'b1);
        end
      end
    join
    @(posedge clk);
    out_rdy <= 1'b1;
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    int i;
    int n;
    void'($urandom(SEED));
    rst_n         <= 1'b0;
    in_s          <= '0;
    out_rdy       <= 1'b1;
    chain_in_s    <= '0;
    chain_out_rdy <= 1'b1;
    fill_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // nothing comes out before the first request
    expect_quiet(4);
    i = 0;
    while (i < NUM_ENTRIES) begin
      if (tbl[i].stall) begin
        // neighbouring stalled entries form one burst
        n = 1;
        while ((i + n < NUM_ENTRIES) && tbl[i + n].stall) begin
          n++;
        end
        burst_with_stalls(i, n);
        i = i + n;
      end else begin
        run_entry(tbl[i]);
        i = i + 1;
      end
    end
    // no late duplicates
    expect_quiet(8);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/xbar_pkg.sv
design/msg_pkg.sv
design/msg_router.sv
design/blocking_xbar.sv
design/rr_arbiter.sv
design/interconnect_top.sv
testbench/tb_clock_gen.sv
testbench/tb_interconnect.sv

//--- run_sim.sh
#!/bin/sh
# build and run the interconnect testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_interconnect -f src.f

# a failing run exits nonzero, the log search below gives the verdict
./obj_dir/Vtb_interconnect > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
